/* timing_core_macros.svh */
/*
 Register map, reset values and readback slots of the timing core.
 Included by the modules that decode or build register words.
*/
`ifndef TIMING_CORE_MACROS_SVH
`define TIMING_CORE_MACROS_SVH

////////////////////
// Settings bus map

// Miscellaneous control block
`define SR_MISC          0
`define SR_CLK_OFS       0
`define SR_SER_OFS       1
`define SR_ADC_OFS       2
`define SR_LED_SW_OFS    3
`define SR_PHY_OFS       4
`define SR_LED_SRC_OFS   6

// Time block, high word first then low word
`define SR_TIME64        10
`define SR_TIME_HI_OFS   0
`define SR_TIME_LO_OFS   1

// LEDs 4..1 follow hardware status out of reset
`define LED_SRC_RESET    8'b0001_1110

////////////////////
// Readback

// Bump when the register interface changes
`define COMPAT_MAJOR     8
`define COMPAT_MINOR     0

`define RB_WORD_STATUS   8
`define RB_WORD_TIME_HI  10
`define RB_WORD_TIME_LO  11
`define RB_WORD_COMPAT   12
`define RB_WORD_PPS_HI   14
`define RB_WORD_PPS_LO   15

`endif

/* timing_core_pkg.sv */
/*
 Shared widths and packed structs of the timing core.
 Referenced by scoped names from every module of the design.
*/
package timing_core_pkg;

   ////////////////////
   // Widths

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [63:0] vita_time_t;
   typedef logic [3:0]  rb_addr_t;
   typedef logic [7:0]  led_t;

   ////////////////////
   // Settings bus

   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   // One write select per target register
   typedef struct packed {
      logic clk;
      logic ser;
      logic adc;
      logic led_sw;
      logic phy;
      logic led_src;
      logic time_hi;
      logic time_lo;
   } set_sel_t;

   typedef struct packed {
      set_sel_t  sel;
      set_data_t data;
   } set_wr_t;

   ////////////////////
   // Control and status

   // Field order matches the low bits of the data word
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clk_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   typedef struct packed {
      logic run_rx;
      logic run_tx;
      logic clk_status;
      logic link_up;
   } hw_status_t;

endpackage

/* settings_decoder.sv */
/*
 First pipeline stage of the timing core. Registers each settings write
 and turns its address into a single write select for the second stage.
*/
`timescale 1ns/1ps
`include "timing_core_macros.svh"

module settings_decoder (
   input  logic                        dsp_clk,
   input  logic                        por_rst,
   input  timing_core_pkg::set_bus_t   set_bus_i,
   output timing_core_pkg::set_wr_t    wr_o
);

   // Absolute addresses of every target register
   localparam timing_core_pkg::set_addr_t ADDR_CLK =
      timing_core_pkg::set_addr_t'(`SR_MISC + `SR_CLK_OFS);
   localparam timing_core_pkg::set_addr_t ADDR_SER =
      timing_core_pkg::set_addr_t'(`SR_MISC + `SR_SER_OFS);
   localparam timing_core_pkg::set_addr_t ADDR_ADC =
      timing_core_pkg::set_addr_t'(`SR_MISC + `SR_ADC_OFS);
   localparam timing_core_pkg::set_addr_t ADDR_LED_SW =
      timing_core_pkg::set_addr_t'(`SR_MISC + `SR_LED_SW_OFS);
   localparam timing_core_pkg::set_addr_t ADDR_PHY =
      timing_core_pkg::set_addr_t'(`SR_MISC + `SR_PHY_OFS);
   localparam timing_core_pkg::set_addr_t ADDR_LED_SRC =
      timing_core_pkg::set_addr_t'(`SR_MISC + `SR_LED_SRC_OFS);
   localparam timing_core_pkg::set_addr_t ADDR_TIME_HI =
      timing_core_pkg::set_addr_t'(`SR_TIME64 + `SR_TIME_HI_OFS);
   localparam timing_core_pkg::set_addr_t ADDR_TIME_LO =
      timing_core_pkg::set_addr_t'(`SR_TIME64 + `SR_TIME_LO_OFS);

   timing_core_pkg::set_sel_t  sel_next;
   timing_core_pkg::set_sel_t  sel_q;
   timing_core_pkg::set_data_t data_q;

   // Address compare, unmapped addresses select nothing
   always_comb begin
      sel_next = '0;
      if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            ADDR_CLK:     sel_next.clk     = 1'b1;
            ADDR_SER:     sel_next.ser     = 1'b1;
            ADDR_ADC:     sel_next.adc     = 1'b1;
            ADDR_LED_SW:  sel_next.led_sw  = 1'b1;
            ADDR_PHY:     sel_next.phy     = 1'b1;
            ADDR_LED_SRC: sel_next.led_src = 1'b1;
            ADDR_TIME_HI: sel_next.time_hi = 1'b1;
            ADDR_TIME_LO: sel_next.time_lo = 1'b1;
            default:      sel_next         = '0;
         endcase
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         sel_q <= '0;
      end else begin
         sel_q <= sel_next;
      end
   end

   // Data only moves on a strobe
   always_ff @(posedge dsp_clk) begin
      if (set_bus_i.stb) begin
         data_q <= set_bus_i.data;
      end
   end

   assign wr_o.sel  = sel_q;
   assign wr_o.data = data_q;

   // Second stage relies on a single target per write
   a_sel_onehot: assert property (@(posedge dsp_clk) disable iff (por_rst)
      $onehot0(wr_o.sel))
      else $error("settings_decoder: more than one write select");

endmodule

/* control_regs.sv */
/*
 Miscellaneous control registers loaded from decoded settings writes.
 Drives clock, SERDES, ADC and PHY controls and the LED source mux.
*/
`timescale 1ns/1ps
`include "timing_core_macros.svh"

module control_regs (
   input  logic                          dsp_clk,
   input  logic                          por_rst,
   input  timing_core_pkg::set_wr_t      wr_i,
   input  timing_core_pkg::hw_status_t   hw_i,
   output timing_core_pkg::clk_ctrl_t    clk_ctrl_o,
   output timing_core_pkg::serdes_ctrl_t serdes_ctrl_o,
   output timing_core_pkg::adc_ctrl_t    adc_ctrl_o,
   output logic                          phy_reset_n_o,
   output timing_core_pkg::led_t         leds_o
);

   localparam int CLK_W = $bits(timing_core_pkg::clk_ctrl_t);
   localparam int SER_W = $bits(timing_core_pkg::serdes_ctrl_t);
   localparam int ADC_W = $bits(timing_core_pkg::adc_ctrl_t);
   localparam int LED_W = $bits(timing_core_pkg::led_t);

   timing_core_pkg::clk_ctrl_t    clk_q;
   timing_core_pkg::serdes_ctrl_t ser_q;
   timing_core_pkg::adc_ctrl_t    adc_q;
   timing_core_pkg::led_t         led_sw_q;
   timing_core_pkg::led_t         led_src_q;
   timing_core_pkg::led_t         led_hw;
   logic                          phy_q;

   ////////////////////
   // Register file

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clk_q     <= '0;
         ser_q     <= '0;
         adc_q     <= '0;
         led_sw_q  <= '0;
         phy_q     <= 1'b0;
         led_src_q <= `LED_SRC_RESET;
      end else begin
         if (wr_i.sel.clk) begin
            clk_q <= timing_core_pkg::clk_ctrl_t'(wr_i.data[CLK_W-1:0]);
         end
         if (wr_i.sel.ser) begin
            ser_q <= timing_core_pkg::serdes_ctrl_t'(wr_i.data[SER_W-1:0]);
         end
         if (wr_i.sel.adc) begin
            adc_q <= timing_core_pkg::adc_ctrl_t'(wr_i.data[ADC_W-1:0]);
         end
         if (wr_i.sel.led_sw) begin
            led_sw_q <= wr_i.data[LED_W-1:0];
         end
         if (wr_i.sel.phy) begin
            phy_q <= wr_i.data[0];
         end
         if (wr_i.sel.led_src) begin
            led_src_q <= wr_i.data[LED_W-1:0];
         end
      end
   end

   assign clk_ctrl_o    = clk_q;
   assign serdes_ctrl_o = ser_q;
   assign adc_ctrl_o    = adc_q;

   // PHY is held in reset while bit 0 is set
   assign phy_reset_n_o = ~phy_q;

   ////////////////////
   // LED mux

   // Source bit 1 picks hardware status, 0 picks software
   assign led_hw = {3'b000, hw_i.run_tx, hw_i.run_rx, hw_i.clk_status, hw_i.link_up, 1'b0};
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   a_led_src_reset: assert property (@(posedge dsp_clk)
      $fell(por_rst) |-> (led_src_q == `LED_SRC_RESET))
      else $error("control_regs: LED source not at reset value");

endmodule

/* vita_timer.sv */
/*
 64-bit time counter with a two-word load and PPS capture.
 Time advances by one per clock; each PPS rising edge latches it.
*/
`timescale 1ns/1ps

module vita_timer (
   input  logic                        dsp_clk,
   input  logic                        por_rst,
   input  timing_core_pkg::set_wr_t    wr_i,
   input  logic                        pps_i,
   output timing_core_pkg::vita_time_t vita_time_o,
   output timing_core_pkg::vita_time_t vita_time_pps_o,
   output logic                        pps_int_o
);

   timing_core_pkg::set_data_t  time_hi_q;
   timing_core_pkg::vita_time_t time_q;
   timing_core_pkg::vita_time_t time_next;
   timing_core_pkg::vita_time_t time_pps_q;
   logic                        pps_meta_q;
   logic                        pps_sync_q;
   logic                        pps_last_q;
   logic                        pps_rise;
   logic                        pps_int_q;

   ////////////////////
   // Time counter

   // High word waits here until the low word arrives
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_hi_q <= '0;
      end else if (wr_i.sel.time_hi) begin
         time_hi_q <= wr_i.data;
      end
   end

   always_comb begin
      if (wr_i.sel.time_lo) begin
         time_next = {time_hi_q, wr_i.data};
      end else begin
         time_next = time_q + 64'd1;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_q <= '0;
      end else begin
         time_q <= time_next;
      end
   end

   ////////////////////
   // PPS

   // Two flops against metastability, a third for the edge
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_meta_q <= 1'b0;
         pps_sync_q <= 1'b0;
         pps_last_q <= 1'b0;
      end else begin
         pps_meta_q <= pps_i;
         pps_sync_q <= pps_meta_q;
         pps_last_q <= pps_sync_q;
      end
   end

   assign pps_rise = pps_sync_q & ~pps_last_q;

   // Latch the value the counter takes at this edge,
   // so it matches the time shown while the pulse is high
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_int_q  <= 1'b0;
         time_pps_q <= '0;
      end else begin
         pps_int_q <= pps_rise;
         if (pps_rise) begin
            time_pps_q <= time_next;
         end
      end
   end

   assign vita_time_o     = time_q;
   assign vita_time_pps_o = time_pps_q;
   assign pps_int_o       = pps_int_q;

   a_pps_single: assert property (@(posedge dsp_clk) disable iff (por_rst)
      pps_int_o |=> !pps_int_o)
      else $error("vita_timer: PPS pulse longer than one cycle");

endmodule

/* status_readback.sv */
/*
 Registered readback mux over 16 word slots.
 Returns status, time, PPS time and the compatibility number.
*/
`timescale 1ns/1ps
`include "timing_core_macros.svh"

module status_readback (
   input  logic                        dsp_clk,
   input  logic                        por_rst,
   input  timing_core_pkg::rb_addr_t   rb_addr_i,
   input  timing_core_pkg::hw_status_t hw_i,
   input  timing_core_pkg::vita_time_t vita_time_i,
   input  timing_core_pkg::vita_time_t vita_time_pps_i,
   output timing_core_pkg::set_data_t  rb_data_o
);

   localparam timing_core_pkg::rb_addr_t SLOT_STATUS  = 4'(`RB_WORD_STATUS);
   localparam timing_core_pkg::rb_addr_t SLOT_TIME_HI = 4'(`RB_WORD_TIME_HI);
   localparam timing_core_pkg::rb_addr_t SLOT_TIME_LO = 4'(`RB_WORD_TIME_LO);
   localparam timing_core_pkg::rb_addr_t SLOT_COMPAT  = 4'(`RB_WORD_COMPAT);
   localparam timing_core_pkg::rb_addr_t SLOT_PPS_HI  = 4'(`RB_WORD_PPS_HI);
   localparam timing_core_pkg::rb_addr_t SLOT_PPS_LO  = 4'(`RB_WORD_PPS_LO);

   // Major in the upper half, minor in the lower half
   localparam timing_core_pkg::set_data_t COMPAT_WORD = {16'(`COMPAT_MAJOR), 16'(`COMPAT_MINOR)};

   localparam int PAD_W = $bits(timing_core_pkg::set_data_t) - $bits(timing_core_pkg::hw_status_t);

   timing_core_pkg::set_data_t rb_next;
   timing_core_pkg::set_data_t rb_q;

   always_comb begin
      case (rb_addr_i)
         SLOT_STATUS:  rb_next = {{PAD_W{1'b0}}, hw_i};
         SLOT_TIME_HI: rb_next = vita_time_i[63:32];
         SLOT_TIME_LO: rb_next = vita_time_i[31:0];
         SLOT_COMPAT:  rb_next = COMPAT_WORD;
         SLOT_PPS_HI:  rb_next = vita_time_pps_i[63:32];
         SLOT_PPS_LO:  rb_next = vita_time_pps_i[31:0];
         default:      rb_next = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_q <= '0;
      end else begin
         rb_q <= rb_next;
      end
   end

   assign rb_data_o = rb_q;

endmodule

/* timing_core_top.sv */
/*
 Top level of the sample-clock timing core. Settings writes pass the
 decoder stage, then reach the control registers and the time counter.
*/
`timescale 1ns/1ps

module timing_core_top (
   input  logic                          dsp_clk,
   input  logic                          por_rst,
   input  timing_core_pkg::set_bus_t     set_bus_i,
   input  timing_core_pkg::hw_status_t   hw_i,
   input  logic                          pps_i,
   input  timing_core_pkg::rb_addr_t     rb_addr_i,
   output timing_core_pkg::clk_ctrl_t    clk_ctrl_o,
   output timing_core_pkg::serdes_ctrl_t serdes_ctrl_o,
   output timing_core_pkg::adc_ctrl_t    adc_ctrl_o,
   output logic                          phy_reset_n_o,
   output timing_core_pkg::led_t         leds_o,
   output timing_core_pkg::vita_time_t   vita_time_o,
   output logic                          pps_int_o,
   output timing_core_pkg::set_data_t    rb_data_o
);

   timing_core_pkg::set_wr_t    wr;
   timing_core_pkg::vita_time_t vita_time_pps;

   ////////////////////
   // Decode stage

   settings_decoder u_decoder (
      .dsp_clk   (dsp_clk),
      .por_rst   (por_rst),
      .set_bus_i (set_bus_i),
      .wr_o      (wr)
   );

   ////////////////////
   // Register, timer and readback stage

   control_regs u_control (
      .dsp_clk       (dsp_clk),
      .por_rst       (por_rst),
      .wr_i          (wr),
      .hw_i          (hw_i),
      .clk_ctrl_o    (clk_ctrl_o),
      .serdes_ctrl_o (serdes_ctrl_o),
      .adc_ctrl_o    (adc_ctrl_o),
      .phy_reset_n_o (phy_reset_n_o),
      .leds_o        (leds_o)
   );

   vita_timer u_timer (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .wr_i            (wr),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time_o),
      .vita_time_pps_o (vita_time_pps),
      .pps_int_o       (pps_int_o)
   );

   // Reads the same time that leaves the top
   status_readback u_readback (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .rb_addr_i       (rb_addr_i),
      .hw_i            (hw_i),
      .vita_time_i     (vita_time_o),
      .vita_time_pps_i (vita_time_pps),
      .rb_data_o       (rb_data_o)
   );

endmodule

/* tb_timing_core.sv */
/*
 Self-checking random testbench of the timing core. A cycle model runs at
 the falling edge and checks every DUT output once per clock.
*/
`timescale 1ns/1ps
`include "timing_core_macros.svh"

module tb_timing_core;

   localparam int CLK_PERIOD  = 100;
   localparam int CTRL_WRITES = 300;
   localparam int LED_WRITES  = 100;
   localparam int TIME_LOADS  = 4;
   localparam int PPS_EDGES   = 20;
   // Worst case length of every phase, reset and tail included
   localparam int TEST_CYCLES = 12 + CTRL_WRITES + 2 * LED_WRITES + 14 * TIME_LOADS
                                + 20 * PPS_EDGES + 32 + 20;
   localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * CLK_PERIOD;

   localparam logic [7:0] A_CLK     = 8'(`SR_MISC + `SR_CLK_OFS);
   localparam logic [7:0] A_SER     = 8'(`SR_MISC + `SR_SER_OFS);
   localparam logic [7:0] A_ADC     = 8'(`SR_MISC + `SR_ADC_OFS);
   localparam logic [7:0] A_LED_SW  = 8'(`SR_MISC + `SR_LED_SW_OFS);
   localparam logic [7:0] A_PHY     = 8'(`SR_MISC + `SR_PHY_OFS);
   localparam logic [7:0] A_LED_SRC = 8'(`SR_MISC + `SR_LED_SRC_OFS);
   localparam logic [7:0] A_TIME_HI = 8'(`SR_TIME64 + `SR_TIME_HI_OFS);
   localparam logic [7:0] A_TIME_LO = 8'(`SR_TIME64 + `SR_TIME_LO_OFS);

   logic                          dsp_clk = 1'b0;
   logic                          por_rst;
   timing_core_pkg::set_bus_t     set_bus_i;
   timing_core_pkg::hw_status_t   hw_i;
   logic                          pps_i;
   timing_core_pkg::rb_addr_t     rb_addr_i;
   timing_core_pkg::clk_ctrl_t    clk_ctrl_o;
   timing_core_pkg::serdes_ctrl_t serdes_ctrl_o;
   timing_core_pkg::adc_ctrl_t    adc_ctrl_o;
   logic                          phy_reset_n_o;
   timing_core_pkg::led_t         leds_o;
   timing_core_pkg::vita_time_t   vita_time_o;
   logic                          pps_int_o;
   timing_core_pkg::set_data_t    rb_data_o;

   integer seed        = 32'hcff4_5013;
   int     error_count = 0;
   int     check_count = 0;
   int     pps_rises   = 0;
   int     pps_pulses  = 0;
   string  test_name   = "reset";
   bit     model_valid = 1'b0;

   ////////////////////
   // Model state

   logic [4:0]  clk_m;
   logic [3:0]  ser_m;
   logic [3:0]  adc_m;
   logic [7:0]  led_sw_m;
   logic [7:0]  led_src_m;
   logic        phy_m;
   logic [31:0] time_hi_m;
   logic [63:0] time_m;
   logic [63:0] pps_time_m;
   logic        pps_last_m;
   logic [31:0] rb_m;
   logic        dec_stb_m;
   logic [7:0]  dec_addr_m;
   logic [31:0] dec_data_m;

   timing_core_top i_dut (
      .dsp_clk       (dsp_clk),
      .por_rst       (por_rst),
      .set_bus_i     (set_bus_i),
      .hw_i          (hw_i),
      .pps_i         (pps_i),
      .rb_addr_i     (rb_addr_i),
      .clk_ctrl_o    (clk_ctrl_o),
      .serdes_ctrl_o (serdes_ctrl_o),
      .adc_ctrl_o    (adc_ctrl_o),
      .phy_reset_n_o (phy_reset_n_o),
      .leds_o        (leds_o),
      .vita_time_o   (vita_time_o),
      .pps_int_o     (pps_int_o),
      .rb_data_o     (rb_data_o)
   );

   always #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;

   task automatic check_value(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("Error [%s] %s: expected 0x%h, actual 0x%h",
                  test_name, what, expected, actual);
      end
   endtask

   // Hardware LEDs are run_tx, run_rx, clk_status, link_up on bits 4..1
   function automatic logic [7:0] led_expect(input logic [7:0] src, input logic [7:0] sw,
                                             input timing_core_pkg::hw_status_t hw);
      logic [7:0] hw_vec;
      hw_vec    = 8'h00;
      hw_vec[4] = hw.run_tx;
      hw_vec[3] = hw.run_rx;
      hw_vec[2] = hw.clk_status;
      hw_vec[1] = hw.link_up;
      for (int i = 0; i < 8; i++) begin
         led_expect[i] = src[i] ? hw_vec[i] : sw[i];
      end
   endfunction

   function automatic logic [31:0] rb_word(input logic [3:0] slot,
                                           input timing_core_pkg::hw_status_t hw,
                                           input logic [63:0] t, input logic [63:0] pps_t);
      case (int'(slot))
         `RB_WORD_STATUS:  rb_word = {28'd0, hw};
         `RB_WORD_TIME_HI: rb_word = t[63:32];
         `RB_WORD_TIME_LO: rb_word = t[31:0];
         `RB_WORD_COMPAT:  rb_word = 32'((`COMPAT_MAJOR << 16) | `COMPAT_MINOR);
         `RB_WORD_PPS_HI:  rb_word = pps_t[63:32];
         `RB_WORD_PPS_LO:  rb_word = pps_t[31:0];
         default:          rb_word = 32'd0;
      endcase
   endfunction

   ////////////////////
   // Cycle model

   // Check the current state, then step it with the inputs the next edge samples
   always @(negedge dsp_clk) begin
      if (model_valid) begin
         check_value("clk_ctrl", 64'(clk_m), 64'(clk_ctrl_o));
         check_value("serdes_ctrl", 64'(ser_m), 64'(serdes_ctrl_o));
         check_value("adc_ctrl", 64'(adc_m), 64'(adc_ctrl_o));
         check_value("phy_reset_n", 64'(!phy_m), 64'(phy_reset_n_o));
         check_value("leds", 64'(led_expect(led_src_m, led_sw_m, hw_i)), 64'(leds_o));
         check_value("vita_time", time_m, vita_time_o);
         check_value("rb_data", 64'(rb_m), 64'(rb_data_o));
         check_value("pps pulse width", 64'd0, 64'(pps_int_o & pps_last_m));
         if (pps_int_o === 1'b1) begin
            pps_pulses++;
            pps_time_m = time_m;
         end
         pps_last_m = pps_int_o;
      end
      if (por_rst) begin
         clk_m      = '0;
         ser_m      = '0;
         adc_m      = '0;
         led_sw_m   = '0;
         led_src_m  = `LED_SRC_RESET;
         phy_m      = 1'b0;
         time_hi_m  = '0;
         time_m     = '0;
         pps_time_m = '0;
         pps_last_m = 1'b0;
         rb_m       = '0;
         dec_stb_m  = 1'b0;
         dec_addr_m = '0;
         dec_data_m = '0;
      end else begin
         rb_m   = rb_word(rb_addr_i, hw_i, time_m, pps_time_m);
         time_m = time_m + 64'd1;
         if (dec_stb_m) begin
            case (dec_addr_m)
               A_CLK:     clk_m     = dec_data_m[4:0];
               A_SER:     ser_m     = dec_data_m[3:0];
               A_ADC:     adc_m     = dec_data_m[3:0];
               A_LED_SW:  led_sw_m  = dec_data_m[7:0];
               A_PHY:     phy_m     = dec_data_m[0];
               A_LED_SRC: led_src_m = dec_data_m[7:0];
               A_TIME_HI: time_hi_m = dec_data_m;
               A_TIME_LO: time_m    = {time_hi_m, dec_data_m};
               default:   ;
            endcase
         end
         dec_stb_m = set_bus_i.stb;
         if (set_bus_i.stb) begin
            dec_addr_m = set_bus_i.addr;
            dec_data_m = set_bus_i.data;
         end
      end
      model_valid = 1'b1;
   end

   ////////////////////
   // Stimulus

   task automatic drive_cycle(input bit stb, input logic [7:0] addr, input logic [31:0] data,
                              input bit pps_slots);
      timing_core_pkg::set_bus_t bus;
      logic [31:0]               r;
      r        = $random(seed);
      bus.stb  = stb;
      bus.addr = addr;
      bus.data = data;
      @(posedge dsp_clk);
      set_bus_i <= bus;
      hw_i      <= timing_core_pkg::hw_status_t'(r[3:0]);
      if (pps_slots) begin
         rb_addr_i <= r[4] ? 4'(`RB_WORD_PPS_HI) : 4'(`RB_WORD_PPS_LO);
      end else begin
         rb_addr_i <= r[11:8];
      end
   endtask

   // Bus stays busy with random address and data but no strobe
   task automatic idle_cycles(input int n, input bit pps_slots);
      repeat (n) begin
         drive_cycle(1'b0, 8'($random(seed)), 32'($random(seed)), pps_slots);
      end
   endtask

   task automatic random_writes(input int n);
      logic [31:0] r;
      repeat (n) begin
         r = $random(seed);
         // Mostly the low 16 addresses where the map lives
         drive_cycle(r[1:0] != 2'b00, r[2] ? {4'h0, r[7:4]} : r[15:8],
                     32'($random(seed)), 1'b0);
      end
   endtask

   task automatic led_writes(input int n);
      logic [31:0] r;
      repeat (n) begin
         r = $random(seed);
         drive_cycle(1'b1, r[0] ? A_LED_SRC : A_LED_SW, 32'($random(seed)), 1'b0);
         idle_cycles(1, 1'b0);
      end
   endtask

   task automatic load_time(input logic [63:0] value);
      drive_cycle(1'b1, A_TIME_HI, value[63:32], 1'b0);
      drive_cycle(1'b1, A_TIME_LO, value[31:0], 1'b0);
      idle_cycles(2, 1'b0);
      for (int k = 0; k < 10; k++) begin
         @(negedge dsp_clk);
         check_value("loaded time", value + 64'(k), vita_time_o);
         idle_cycles(1, 1'b0);
      end
   endtask

   // High and low phases of 2 to 9 cycles each
   task automatic pps_edges(input int n);
      logic [31:0] r;
      repeat (n) begin
         r = $random(seed);
         idle_cycles(1, 1'b1);
         pps_i <= 1'b1;
         pps_rises++;
         idle_cycles(2 + int'(r[2:0]), 1'b1);
         pps_i <= 1'b0;
         idle_cycles(2 + int'(r[6:4]), 1'b1);
      end
   endtask

   task automatic sweep_readback();
      for (int slot = 0; slot < 16; slot++) begin
         @(posedge dsp_clk);
         set_bus_i <= '0;
         rb_addr_i <= 4'(slot);
         @(posedge dsp_clk);
         @(negedge dsp_clk);
         if (slot == `RB_WORD_COMPAT) begin
            check_value("compat word", 64'h0000_0000_0008_0000, 64'(rb_data_o));
         end
      end
   endtask

   initial begin
      logic [63:0] load_value;
      por_rst   = 1'b1;
      set_bus_i = '0;
      hw_i      = '0;
      pps_i     = 1'b0;
      rb_addr_i = '0;
      repeat (2) @(posedge dsp_clk);
      por_rst <= 1'b0;
      @(negedge dsp_clk);
      check_value("phy_reset_n", 64'd1, 64'(phy_reset_n_o));
      check_value("vita_time", 64'd0, vita_time_o);
      idle_cycles(10, 1'b0);

      test_name = "control_writes";
      random_writes(CTRL_WRITES);
      test_name = "led_mux";
      led_writes(LED_WRITES);

      test_name = "time_load";
      // First load crosses the carry from the low into the high word
      load_time(64'hFFFF_FFFF_FFFF_FFFA);
      repeat (TIME_LOADS - 1) begin
         load_value[63:32] = $random(seed);
         load_value[31:0]  = $random(seed);
         load_time(load_value);
      end

      test_name = "pps_capture";
      pps_edges(PPS_EDGES);
      idle_cycles(8, 1'b0);
      check_value("pulse count", 64'(pps_rises), 64'(pps_pulses));

      test_name = "readback_map";
      sweep_readback();
      idle_cycles(10, 1'b0);

      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

/* build.f */
+incdir+.
timing_core_pkg.sv
settings_decoder.sv
control_regs.sv
vita_timer.sv
status_readback.sv
timing_core_top.sv
tb_timing_core.sv

/* Makefile */
# Verilator simulation of the timing core

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_timing_core
FILELIST  := build.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: sim clean

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q -F "*** PASSED ***" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
